//--- Bender.yml
package:
  name: cpu8

sources:
  # rtl in compile order
  - common/cpu8_pkg.sv
  - hdl/cpu8_regfile.sv
  - hdl/cpu8_alu.sv
  - core/cpu8_decoder.sv
  - core/cpu8_sequencer.sv
  - core/cpu8_core.sv
  # testbench
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_cpu8.sv

//--- common/cpu8_pkg.sv
// cpu8 shared definitions
// widths, register indices, opcode fields, fsm and alu encodings

package cpu8_pkg;

  // --------------------
  // widths
  localparam int word_bits = 8;
  localparam int addr_bits = 8;
  localparam int num_regs  = 4;
  localparam int reg_bits  = $clog2(num_regs);
  localparam int imm_bit   = word_bits - 3;  // set when an immediate word follows

  typedef logic [word_bits-1:0] word_t;
  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [reg_bits-1:0]  reg_idx_t;

  // special registers
  localparam reg_idx_t sp_idx     = 2'd0;  // stack pointer
  localparam reg_idx_t status_idx = 2'd3;  // compare flags
  localparam addr_t    entry_addr = 8'h00;  // pc after reset

  // --------------------
  // zero-reg opcodes in the 5 bit field
  localparam logic [4:0] op_halt   = 5'd0;
  localparam logic [4:0] op_nop    = 5'd1;
  localparam logic [4:0] op_ret    = 5'd2;
  localparam logic [4:0] op_sel_ne = 5'd4;  // selects need a compare before
  localparam logic [4:0] op_sel_gt = 5'd5;
  localparam logic [4:0] op_sel_ge = 5'd6;
  localparam logic [4:0] op_sel_lt = 5'd7;
  localparam logic [4:0] op_sel_le = 5'd8;

  // one-reg with immediate
  localparam logic [2:0] op1_ldi = 3'd0;  // reg = imm
  localparam logic [2:0] op1_ld  = 3'd1;  // reg = mem[imm]
  localparam logic [2:0] op1_st  = 3'd2;  // mem[imm] = reg

  // one-reg without immediate
  localparam logic [2:0] op1_jc   = 3'd0;
  localparam logic [2:0] op1_jmp  = 3'd1;
  localparam logic [2:0] op1_jr   = 3'd2;
  localparam logic [2:0] op1_call = 3'd3;
  localparam logic [2:0] op1_not  = 3'd4;
  localparam logic [2:0] op1_lnot = 3'd5;
  localparam logic [2:0] op1_push = 3'd6;
  localparam logic [2:0] op1_pop  = 3'd7;

  // two-reg ops that redirect the write
  localparam logic [2:0] op2_mov = 3'd0;  // writes idx2
  localparam logic [2:0] op2_cmp = 3'd5;  // writes status

  // status flag positions
  localparam int cmp_eq_bit = 0;
  localparam int cmp_ne_bit = 1;
  localparam int cmp_gt_bit = 2;
  localparam int cmp_ge_bit = 3;
  localparam int cmp_lt_bit = 4;
  localparam int cmp_le_bit = 5;

  // --------------------
  typedef enum logic [2:0] {
    cls_two, cls_one_imm, cls_one, cls_zero_imm, cls_zero
  } instr_class_t;

  // first eight follow the 2-reg opcode order
  typedef enum logic [3:0] {
    alu_mov, alu_add, alu_sub, alu_shl, alu_shr, alu_cmp, alu_and, alu_or,
    alu_bnot, alu_lnot, alu_sel_ne, alu_sel_gt, alu_sel_ge, alu_sel_lt, alu_sel_le
  } alu_op_t;

  typedef enum logic [2:0] {
    cyc_fetch, cyc_decode, cyc_exec, cyc_load_imm, cyc_write_mem, cyc_halt
  } cycle_t;

endpackage

//--- core/cpu8_core.sv
`timescale 1ns/1ps
// cpu8 top level
// sequencer, decoder, register file and alu on one memory bus

module cpu8_core (
  input  logic            in_clk,
  input  logic            in_rst,
  input  logic            mem_ack,
  input  cpu8_pkg::word_t mem_rdata,
  output logic            mem_req,
  output logic            mem_write,
  output cpu8_pkg::addr_t mem_addr,
  output cpu8_pkg::word_t mem_wdata,
  output cpu8_pkg::word_t out_instr,  // debug copy of the current instruction
  output cpu8_pkg::addr_t out_pc      // debug copy of the program counter
);
  import cpu8_pkg::*;

  logic         capture;
  instr_class_t iclass;
  logic [4:0]   sub_op;
  reg_idx_t     idx1, idx2;
  alu_op_t      alu_op;
  word_t        rd_a, rd_b, sp, status;
  word_t        alu_result;
  logic         wr_en;
  reg_idx_t     wr_idx;
  word_t        wr_data;

  cpu8_sequencer u_seq (
    .in_clk, .in_rst, .mem_ack, .mem_rdata, .mem_req, .mem_write, .mem_addr, .mem_wdata,
    .instr(out_instr), .pc(out_pc), .capture, .iclass, .sub_op, .idx1, .idx2,
    .alu_result, .rd_a, .sp, .status, .wr_en, .wr_idx, .wr_data
  );

  // decoder latches the fetched word in its ack cycle
  cpu8_decoder u_dec (
    .in_clk, .in_rst, .capture, .instr(mem_rdata), .iclass, .sub_op, .idx1, .idx2, .alu_op
  );

  cpu8_regfile u_regs (
    .in_clk, .in_rst, .rd_idx_a(idx1), .rd_idx_b(idx2), .rd_a, .rd_b, .sp, .status,
    .wr_en, .wr_idx, .wr_data
  );

  cpu8_alu u_alu (.op(alu_op), .a(rd_a), .b(rd_b), .status, .result(alu_result));

endmodule

//--- core/cpu8_decoder.sv
`timescale 1ns/1ps
// cpu8 decoder
// classifies the fetched word and latches its fields on capture

module cpu8_decoder (
  input  logic                   in_clk,
  input  logic                   in_rst,
  input  logic                   capture,
  input  cpu8_pkg::word_t        instr,
  output cpu8_pkg::instr_class_t iclass,
  output logic [4:0]             sub_op,
  output cpu8_pkg::reg_idx_t     idx1,
  output cpu8_pkg::reg_idx_t     idx2,
  output cpu8_pkg::alu_op_t      alu_op
);
  import cpu8_pkg::*;

  instr_class_t dec_class;
  logic [4:0]   dec_sub;
  reg_idx_t     dec_idx1, dec_idx2;
  alu_op_t      dec_op;
  logic         has_imm;

  assign has_imm = instr[imm_bit];

  always_comb begin
    dec_idx1 = instr[1:0];  // 1-reg operand, 2-reg second operand
    dec_idx2 = instr[1:0];
    dec_op   = alu_mov;
    if (instr[7]) begin  // 1_ooo_aa_bb
      dec_class = cls_two;
      dec_sub   = {2'b00, instr[6:4]};
      dec_idx1  = instr[3:2];
      dec_op    = alu_op_t'({1'b0, instr[6:4]});  // same order as opcodes
    end else if (instr[6]) begin  // 01_i_ooo_aa
      dec_class = has_imm ? cls_one_imm : cls_one;
      dec_sub   = {2'b00, instr[4:2]};
      if (!has_imm && instr[4:2] == op1_not)
        dec_op = alu_bnot;
      else if (!has_imm && instr[4:2] == op1_lnot)
        dec_op = alu_lnot;
    end else begin  // 00_i_ooooo
      dec_class = has_imm ? cls_zero_imm : cls_zero;
      dec_sub   = instr[4:0];
      case (instr[4:0])
        op_sel_ne: dec_op = alu_sel_ne;
        op_sel_gt: dec_op = alu_sel_gt;
        op_sel_ge: dec_op = alu_sel_ge;
        op_sel_lt: dec_op = alu_sel_lt;
        op_sel_le: dec_op = alu_sel_le;
        default:   dec_op = alu_mov;
      endcase
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      iclass <= cls_zero;
      alu_op <= alu_mov;
    end else if (capture) begin
      iclass <= dec_class;
      alu_op <= dec_op;
    end
  end

  always_ff @(posedge in_clk) begin  // operand fields
    if (capture) begin
      sub_op <= dec_sub;
      idx1   <= dec_idx1;
      idx2   <= dec_idx2;
    end
  end

endmodule

//--- core/cpu8_sequencer.sv
`timescale 1ns/1ps
// cpu8 sequencer
// cycle fsm for fetch, immediate load, execute and memory write
// holds pc, instruction register and the memory bus registers

module cpu8_sequencer (
  input  logic                   in_clk,
  input  logic                   in_rst,
  input  logic                   mem_ack,
  input  cpu8_pkg::word_t        mem_rdata,
  output logic                   mem_req,
  output logic                   mem_write,
  output cpu8_pkg::addr_t        mem_addr,
  output cpu8_pkg::word_t        mem_wdata,
  output cpu8_pkg::word_t        instr,
  output cpu8_pkg::addr_t        pc,
  output logic                   capture,
  input  cpu8_pkg::instr_class_t iclass,
  input  logic [4:0]             sub_op,
  input  cpu8_pkg::reg_idx_t     idx1,
  input  cpu8_pkg::reg_idx_t     idx2,
  input  cpu8_pkg::word_t        alu_result,
  input  cpu8_pkg::word_t        rd_a,
  input  cpu8_pkg::word_t        sp,
  input  cpu8_pkg::word_t        status,
  output logic                   wr_en,
  output cpu8_pkg::reg_idx_t     wr_idx,
  output cpu8_pkg::word_t        wr_data
);
  import cpu8_pkg::*;

  cycle_t cycle, next_cycle;
  logic   subcycle, next_subcycle;  // 0 request, 1 wait for ack
  logic   next_mem_req, next_mem_write;
  addr_t  next_pc, next_mem_addr;
  word_t  next_instr, next_mem_wdata;
  word_t  imm, next_imm;           // immediate word

  // --------------------
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      cycle     <= cyc_fetch;
      subcycle  <= 1'b0;
      pc        <= entry_addr;
      mem_req   <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      cycle     <= next_cycle;
      subcycle  <= next_subcycle;
      pc        <= next_pc;
      mem_req   <= next_mem_req;
      mem_write <= next_mem_write;
    end
  end

  always_ff @(posedge in_clk) begin  // payload
    instr     <= next_instr;
    imm       <= next_imm;
    mem_addr  <= next_mem_addr;
    mem_wdata <= next_mem_wdata;
  end

  // --------------------
  always_comb begin
    next_cycle     = cycle;
    next_subcycle  = subcycle;
    next_pc        = pc;
    next_instr     = instr;
    next_imm       = imm;
    next_mem_addr  = mem_addr;
    next_mem_wdata = mem_wdata;
    next_mem_req   = 1'b0;  // reads are one-cycle pulses
    next_mem_write = 1'b0;
    capture        = 1'b0;
    wr_en          = 1'b0;
    wr_idx         = idx1;
    wr_data        = alu_result;

    unique case (cycle)
      cyc_fetch, cyc_load_imm: begin
        if (!subcycle) begin  // read at pc, step pc
          next_mem_addr = pc;
          next_pc       = pc + 1'b1;
          next_mem_req  = 1'b1;
          next_subcycle = 1'b1;
        end else if (mem_ack) begin
          next_subcycle = 1'b0;
          if (cycle == cyc_fetch) begin
            next_instr = mem_rdata;
            capture    = 1'b1;  // decoder takes the same word
            next_cycle = cyc_decode;
          end else begin
            next_imm   = mem_rdata;
            next_cycle = cyc_exec;
          end
        end
      end

      cyc_decode: begin
        if (iclass == cls_one_imm || iclass == cls_zero_imm)
          next_cycle = cyc_load_imm;
        else
          next_cycle = cyc_exec;
      end

      cyc_exec: begin
        next_cycle = cyc_fetch;  // most ops finish here
        unique case (iclass)
          cls_two: begin
            wr_en = 1'b1;
            if (sub_op[2:0] == op2_mov)
              wr_idx = idx2;
            else if (sub_op[2:0] == op2_cmp)
              wr_idx = status_idx;
          end

          cls_one_imm: begin
            case (sub_op[2:0])
              op1_ldi: begin
                wr_en   = 1'b1;
                wr_data = imm;
              end
              op1_ld: begin
                next_cycle = cyc_exec;
                if (!subcycle) begin  // read mem[imm]
                  next_mem_addr = imm;
                  next_mem_req  = 1'b1;
                  next_subcycle = 1'b1;
                end else if (mem_ack) begin
                  wr_en         = 1'b1;
                  wr_data       = mem_rdata;
                  next_subcycle = 1'b0;
                  next_cycle    = cyc_fetch;
                end
              end
              op1_st: begin
                next_mem_addr  = imm;
                next_mem_wdata = rd_a;
                next_cycle     = cyc_write_mem;
              end
              default: next_cycle = cyc_halt;  // unknown
            endcase
          end

          cls_one: begin
            unique case (sub_op[2:0])
              op1_jc: begin
                if (status[0])  // bit 0 holds the selected flag
                  next_pc = rd_a;
              end
              op1_jmp: next_pc = rd_a;
              op1_jr:  next_pc = pc + rd_a;  // pc already past the jump
              op1_call, op1_push: begin  // pre-decrement sp, then store
                wr_en          = 1'b1;
                wr_idx         = sp_idx;
                wr_data        = sp - 1'b1;
                next_mem_addr  = sp - 1'b1;
                next_mem_wdata = (sub_op[2:0] == op1_call) ? pc : rd_a;
                next_cycle     = cyc_write_mem;
                if (sub_op[2:0] == op1_call)
                  next_pc = rd_a;
              end
              op1_not, op1_lnot: wr_en = 1'b1;
              op1_pop: begin
                next_cycle = cyc_exec;
                if (!subcycle) begin  // read at sp, post-increment
                  next_mem_addr = sp;
                  next_mem_req  = 1'b1;
                  next_subcycle = 1'b1;
                  wr_en         = 1'b1;
                  wr_idx        = sp_idx;
                  wr_data       = sp + 1'b1;
                end else if (mem_ack) begin
                  wr_en         = 1'b1;
                  wr_data       = mem_rdata;
                  next_subcycle = 1'b0;
                  next_cycle    = cyc_fetch;
                end
              end
            endcase
          end

          cls_zero: begin
            case (sub_op)
              op_halt: next_cycle = cyc_halt;
              op_nop:  next_cycle = cyc_fetch;
              op_ret: begin
                next_cycle = cyc_exec;
                if (!subcycle) begin  // return address at sp
                  next_mem_addr = sp;
                  next_mem_req  = 1'b1;
                  next_subcycle = 1'b1;
                  wr_en         = 1'b1;
                  wr_idx        = sp_idx;
                  wr_data       = sp + 1'b1;
                end else if (mem_ack) begin
                  next_pc       = mem_rdata;
                  next_subcycle = 1'b0;
                  next_cycle    = cyc_fetch;
                end
              end
              op_sel_ne, op_sel_gt, op_sel_ge, op_sel_lt, op_sel_le: begin
                wr_en  = 1'b1;
                wr_idx = status_idx;
              end
              default: next_cycle = cyc_halt;
            endcase
          end

          cls_zero_imm: next_cycle = cyc_halt;  // no opcodes defined yet
        endcase
      end

      cyc_write_mem: begin  // hold req and write up to the ack
        next_mem_req   = 1'b1;
        next_mem_write = 1'b1;
        next_subcycle  = 1'b1;
        if (subcycle && mem_ack) begin
          next_mem_req   = 1'b0;
          next_mem_write = 1'b0;
          next_subcycle  = 1'b0;
          next_cycle     = cyc_fetch;
        end
      end

      cyc_halt: next_cycle = cyc_halt;
    endcase
  end

endmodule

//--- hdl/cpu8_alu.sv
`timescale 1ns/1ps
// cpu8 alu
// combinational ops for 2-reg, not and status select instructions

module cpu8_alu (
  input  cpu8_pkg::alu_op_t op,
  input  cpu8_pkg::word_t   a,
  input  cpu8_pkg::word_t   b,
  input  cpu8_pkg::word_t   status,
  output cpu8_pkg::word_t   result
);
  import cpu8_pkg::*;

  word_t flags;  // compare result with zeros above bit 5

  always_comb begin
    flags             = '0;
    flags[cmp_eq_bit] = (a == b);
    flags[cmp_ne_bit] = (a != b);
    flags[cmp_gt_bit] = (a > b);
    flags[cmp_ge_bit] = (a >= b);
    flags[cmp_lt_bit] = (a < b);
    flags[cmp_le_bit] = (a <= b);
  end

  // --------------------
  always_comb begin
    result = status;  // selects only touch bit 0
    case (op)
      alu_mov:    result = a;
      alu_add:    result = a + b;  // wraps at 8 bits
      alu_sub:    result = a - b;
      alu_shl:    result = a << b;
      alu_shr:    result = a >> b;
      alu_cmp:    result = flags;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_bnot:   result = ~a;
      alu_lnot:   result = word_t'(a == '0);
      alu_sel_ne: result[0] = status[cmp_ne_bit];
      alu_sel_gt: result[0] = status[cmp_gt_bit];
      alu_sel_ge: result[0] = status[cmp_ge_bit];
      alu_sel_lt: result[0] = status[cmp_lt_bit];
      alu_sel_le: result[0] = status[cmp_le_bit];
      default:    result = a;
    endcase
  end

endmodule

//--- hdl/cpu8_regfile.sv
`timescale 1ns/1ps
// cpu8 register file
// four words, two read ports, one write port, sp and status taps

module cpu8_regfile (
  input  logic               in_clk,
  input  logic               in_rst,
  input  cpu8_pkg::reg_idx_t rd_idx_a,
  input  cpu8_pkg::reg_idx_t rd_idx_b,
  output cpu8_pkg::word_t    rd_a,
  output cpu8_pkg::word_t    rd_b,
  output cpu8_pkg::word_t    sp,      // register 0
  output cpu8_pkg::word_t    status,  // register 3
  input  logic               wr_en,
  input  cpu8_pkg::reg_idx_t wr_idx,
  input  cpu8_pkg::word_t    wr_data
);
  import cpu8_pkg::*;

  word_t regs [num_regs];

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;  // sp starts at 0 so the first push lands at 255
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // async reads
  assign rd_a   = regs[rd_idx_a];
  assign rd_b   = regs[rd_idx_b];
  assign sp     = regs[sp_idx];
  assign status = regs[status_idx];

endmodule

//--- sim.f
common/cpu8_pkg.sv
hdl/cpu8_regfile.sv
hdl/cpu8_alu.sv
core/cpu8_decoder.sv
core/cpu8_sequencer.sv
core/cpu8_core.sv
test/tb_mem_model.sv
test/tb_cpu8.sv

//--- test/cpu8_golden.mem
// @000 program image, one instruction per group, data word at @0F0
// @100 program words, write count, then address value per write, then final pc
@000
61 C5 62 4B 96 69 C0            // 00 ldi r1 ldi r2 add st
61 20 A6 69 C1                  // 07 sub
62 03 61 B7 B6 69 C2            // 0C shl by 3
61 B7 C6 69 C3                  // 13 shr by 3
61 C5 62 5C E6 69 C4            // 18 and
61 C5 F6 69 C5                  // 1F or
51 69 C6                        // 24 not
55 69 C7 55 69 C8               // 27 lnot twice
89 69 C9                        // 2D mov r2 to r1
61 30 62 50 D6 6B CA            // 30 cmp and store status
04 61 3F 62 A1 41 62 B1 6A CB   // 37 sel_ne then jc
05 61 49 62 A2 41 62 B2 6A CC   // 41 sel_gt
06 61 53 62 A3 41 62 B3 6A CD   // 4B sel_ge
07 61 5D 62 A4 41 62 B4 6A CE   // 55 sel_lt
08 61 67 62 A5 41 62 B5 6A CF   // 5F sel_le
65 F0 69 D0                     // 69 ld from F0 then st
61 80 4D                        // 6D call 80
61 11 62 22 59 5A 5E 5D         // 70 push r1 r2 pop r2 r1
69 D2 6A D3                     // 78 store popped values
03                              // 7C unknown opcode
@080
62 5A 6A D1 02                  // subroutine marker and ret
@0F0
7E                              // data for the load
@100
85 17                           // program words, expected writes
C0 10 C1 D5 C2 B8 C3 16         // add sub shl shr
C4 44 C5 DD C6 22 C7 00         // and or not lnot
C8 01 C9 5C CA 32               // lnot mov compare flags
CB A1 CC B2 CD B3 CE A4 CF A5   // select branch markers
D0 7E                           // loaded word
FF 70 D1 5A                     // return address, subroutine marker
FF 11 FE 22 D2 11 D3 22         // pushes then popped values
7D                              // final pc

//--- test/tb_cpu8.sv
`timescale 1ns/1ps
// cpu8 testbench
// runs the golden program under random memory latency
// checks every memory write, the halt pc and a quiet bus after halt

module tb_cpu8;
  import cpu8_pkg::*;

  localparam int image_words  = 512;
  localparam int mem_words    = 256;
  localparam int exp_base     = 'h100;  // expected section of the image
  localparam int quiet_cycles = 20;     // bus watch after halt

  logic  in_clk;
  logic  in_rst;
  logic  mem_ack;
  logic  mem_req;
  logic  mem_write;
  word_t mem_rdata;
  word_t mem_wdata;
  addr_t mem_addr;
  word_t out_instr;
  addr_t out_pc;

  word_t golden [image_words];  // program image plus expected results
  int    errors;
  int    writes_seen;
  int    num_writes;
  int    cycle_limit;
  int    cycles;
  addr_t final_pc;
  addr_t halt_pc;

  // --------------------
  initial in_clk = 1'b0;
  always #4 in_clk = ~in_clk;  // 8 ns period

  cpu8_core UUT (
    .in_clk, .in_rst, .mem_ack, .mem_rdata, .mem_req, .mem_write, .mem_addr, .mem_wdata,
    .out_instr, .out_pc
  );

  tb_mem_model u_mem (
    .in_clk, .in_rst, .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // --------------------
  // every accepted write in order
  always @(posedge in_clk) begin
    int idx;
    if (!in_rst && mem_req && mem_write && mem_ack) begin
      idx = exp_base + 2 + 2 * writes_seen;  // addr, value pairs
      assert (writes_seen < num_writes) else begin
        errors++;
        $display("unexpected write to %h after all %0d expected writes", mem_addr, num_writes);
      end
      if (writes_seen < num_writes) begin
        check_word("mem_addr", golden[idx], mem_addr);
        check_word("mem_wdata", golden[idx + 1], mem_wdata);
      end
      writes_seen++;
    end
  end

  // --------------------
  initial begin
    in_rst      = 1'b1;
    errors      = 0;
    writes_seen = 0;
    cycles      = 0;
    for (int i = 0; i < image_words; i++)
      golden[i] = word_t'(i ^ (i >> 8) ^ 'h5A);  // words the file leaves open
    $readmemh("test/cpu8_golden.mem", golden);
    for (int i = 0; i < mem_words; i++)
      u_mem.mem[i] = golden[i];
    num_writes  = golden[exp_base + 1];
    cycle_limit = 40 * golden[exp_base];  // 40 cycles per program word
    final_pc    = golden[exp_base + 2 + 2 * num_writes];

    repeat (3) @(posedge in_clk);
    in_rst <= 1'b0;

    // run until the sequencer parks in halt
    while (UUT.u_seq.cycle != cyc_halt && cycles < cycle_limit) begin
      @(negedge in_clk);
      cycles++;
    end

    if (UUT.u_seq.cycle == cyc_halt) begin
      halt_pc = out_pc;
      check_word("out_pc", final_pc, out_pc);
      check_word("out_instr", golden[int'(final_pc) - 1], out_instr);  // halting opcode
      repeat (quiet_cycles) begin
        @(negedge in_clk);
        assert (!mem_req) else begin
          errors++;
          $display("memory request at %0d ns after the cpu halted", $time);
        end
        check_word("out_pc", halt_pc, out_pc);
      end
      assert (writes_seen == num_writes) else begin
        errors++;
        $display("saw %0d writes but expected %0d", writes_seen, num_writes);
      end
    end else begin
      errors++;
      $display("timeout, the cpu did not halt within %0d cycles", cycle_limit);
    end

    $display("%0d errors, %0d of %0d writes seen", errors, writes_seen, num_writes);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- test/tb_mem_model.sv
`timescale 1ns/1ps
// testbench memory for cpu8
// 256 words, one request at a time, random latency of 1 to 4 cycles

module tb_mem_model (
  input  logic            in_clk,
  input  logic            in_rst,
  input  logic            mem_req,
  input  logic            mem_write,
  input  cpu8_pkg::addr_t mem_addr,
  input  cpu8_pkg::word_t mem_wdata,
  output logic            mem_ack,
  output cpu8_pkg::word_t mem_rdata
);
  import cpu8_pkg::*;

  word_t       mem [256];  // filled by the testbench top
  logic        busy;
  logic        is_write;
  addr_t       req_addr;
  word_t       req_data;
  int          wait_left;  // edges before the ack
  logic [31:0] rng_state;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    busy      = 1'b0;
    wait_left = 0;
    rng_state = 32'h7134_5a6b;
  end

  // --------------------
  always @(posedge in_clk) begin
    if (in_rst) begin
      mem_ack <= 1'b0;
      busy    <= 1'b0;
    end else begin
      mem_ack <= 1'b0;  // one-cycle ack
      if (busy) begin
        if (wait_left == 0) begin
          mem_ack <= 1'b1;
          busy    <= 1'b0;
          if (is_write)
            mem[req_addr] <= req_data;
          else
            mem_rdata <= mem[req_addr];
        end else begin
          wait_left <= wait_left - 1;
        end
      end else if (mem_req && !mem_ack) begin  // held write still high in its ack cycle
        busy      <= 1'b1;
        is_write  <= mem_write;
        req_addr  <= mem_addr;
        req_data  <= mem_wdata;
        wait_left <= int'(rng_state[1:0]);  // 0..3 gives 1..4 cycles
        rng_state <= xorshift32(rng_state);
      end
    end
  end

endmodule
